// File: Makefile
TOP = bbcMemoryCoreTb

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f flist.f -o $(TOP)
	-./obj_dir/$(TOP) > sim.log 2>&1
	cat sim.log
	! grep -q "ERRORS FOUND" sim.log
	grep -q "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// File: flist.f
+incdir+include
hw/bbcPkg.sv
hw/timingGen.sv
hw/sheilaDecoder.sv
hw/memorySystem.sv
hw/screenAddress.sv
hw/bbcMemoryCore.sv
sim/bbcMemoryCore_assertions.sv
sim/bbcMemoryCoreTb.sv

// File: hw/bbcMemoryCore.sv
`timescale 1ns/1ps

module bbcMemoryCore (
	input  logic               CLK,
	input  logic               reset,
	input  bbcPkg::cpuBusT     cpuBus,
	input  bbcPkg::romLoadT    romLoad,
	input  bbcPkg::latchWriteT latch,
	input  logic [13:0]        frameStoreAddr,
	input  logic [4:0]         rowAddress,
	input  logic               txtMode,
	output logic [7:0]         readData,
	output logic [7:0]         videoData,
	output bbcPkg::ioDeviceE   ioDevice,
	output logic               cpuEn,
	output logic [7:0]         systemLatch
);

	logic ramEn;
	logic procEn;
	logic ioEn;
	logic slowAccess;
	logic [14:0] videoAddr;

	timingGen timer (
		.CLK    (CLK),
		.reset  (reset),
		.ramEn  (ramEn),
		.procEn (procEn),
		.ioEn   (ioEn)
	);

	sheilaDecoder decoder (
		.cpuBus     (cpuBus),
		.ioDevice   (ioDevice),
		.slowAccess (slowAccess)
	);

	// Slow peripherals stretch the cycle to the next ioEn
	assign cpuEn = slowAccess ? ioEn : procEn;

	memorySystem memory (
		.CLK       (CLK),
		.reset     (reset),
		.ramEn     (ramEn),
		.procEn    (procEn),
		.cpuEn     (cpuEn),
		.cpuBus    (cpuBus),
		.ioDevice  (ioDevice),
		.romLoad   (romLoad),
		.videoAddr (videoAddr),
		.readData  (readData),
		.videoData (videoData)
	);

	screenAddress screen (
		.CLK            (CLK),
		.reset          (reset),
		.procEn         (procEn),
		.latch          (latch),
		.frameStoreAddr (frameStoreAddr),
		.rowAddress     (rowAddress),
		.txtMode        (txtMode),
		.videoAddr      (videoAddr),
		.systemLatch    (systemLatch)
	);

endmodule

// File: hw/bbcPkg.sv
package bbcPkg;

	// Processor request, held until the cycle after cpuEn
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  wData;
		logic        rnw;
	} cpuBusT;

	// Boot loader byte write into the OS ROM or a sideways bank
	typedef struct packed {
		logic        load;
		logic        osRom;
		logic [1:0]  bank;
		logic [13:0] addr;
		logic [7:0]  data;
	} romLoadT;

	// Addressable latch write, one bit at a time
	typedef struct packed {
		logic       strobe;
		logic [2:0] addr;
		logic       data;
	} latchWriteT;

	typedef enum logic [3:0] {
		ioNone, ioCrtc, ioAcia, ioVidProc, ioRomSel, ioSysVia,
		ioUsrVia, ioFdc, ioAdlc, ioAdc, ioTube
	} ioDeviceE;

endpackage

// File: hw/memorySystem.sv
`timescale 1ns/1ps

`include "bbc_macros.svh"

module memorySystem (
	input  logic              CLK,
	input  logic              reset,
	input  logic              ramEn,
	input  logic              procEn,
	input  logic              cpuEn,
	input  bbcPkg::cpuBusT    cpuBus,
	input  bbcPkg::ioDeviceE  ioDevice,
	input  bbcPkg::romLoadT   romLoad,
	input  logic [14:0]       videoAddr,
	output logic [7:0]        readData,
	output logic [7:0]        videoData
);

	import bbcPkg::*;

	localparam int BankBits = $clog2(`SIDEWAYS_BANKS);

	logic [7:0] ram [`RAM_WORDS];
	logic [7:0] osRom [`ROM_WORDS];
	// Banks stacked end to end, indexed by {bank, offset}
	logic [7:0] sidewaysRom [`SIDEWAYS_BANKS*`ROM_WORDS];

	logic [BankBits-1:0] romSel;
	logic [7:0] ramData;
	logic [7:0] romData;
	logic inSheila;
	logic osWindow;
	logic swWindow;
	logic cpuSlot;

	assign inSheila = (cpuBus.addr[15:8] == `SHEILA_PAGE);
	assign osWindow = (cpuBus.addr[15:14] == 2'b11);
	assign swWindow = (cpuBus.addr[15:14] == 2'b10);
	assign cpuSlot = ramEn && !procEn;

	// Paged ROM select, written through FE30 to FE3F
	always_ff @(posedge CLK) begin
		if (reset) begin
			romSel <= '0;
		end else if (cpuEn && ioDevice == ioRomSel) begin
			romSel <= cpuBus.wData[BankBits-1:0];
		end
	end

	// Video slot on procEn phases, processor slot on the rest
	always_ff @(posedge CLK) begin
		if (ramEn) begin
			if (procEn) begin
				videoData <= ram[videoAddr];
			end else if (cpuBus.rnw) begin
				ramData <= ram[cpuBus.addr[14:0]];
			end else if (!cpuBus.addr[15]) begin
				ram[cpuBus.addr[14:0]] <= cpuBus.wData;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (cpuSlot) begin
			if (osWindow) begin
				romData <= osRom[cpuBus.addr[13:0]];
			end else if (swWindow) begin
				romData <= sidewaysRom[{romSel, cpuBus.addr[13:0]}];
			end
		end
	end

	// Boot loader fill, one byte per cycle
	always_ff @(posedge CLK) begin
		if (romLoad.load && romLoad.osRom) begin
			osRom[romLoad.addr] <= romLoad.data;
		end
	end

	always_ff @(posedge CLK) begin
		if (romLoad.load && !romLoad.osRom) begin
			sidewaysRom[{romLoad.bank, romLoad.addr}] <= romLoad.data;
		end
	end

	// I/O data bus not modelled, SHEILA floats high
	assign readData = inSheila ? 8'hFF : (cpuBus.addr[15] ? romData : ramData);

endmodule

// File: hw/screenAddress.sv
`timescale 1ns/1ps

module screenAddress (
	input  logic               CLK,
	input  logic               reset,
	input  logic               procEn,
	input  bbcPkg::latchWriteT latch,
	input  logic [13:0]        frameStoreAddr,
	input  logic [4:0]         rowAddress,
	input  logic               txtMode,
	output logic [14:0]        videoAddr,
	output logic [7:0]         systemLatch
);

	logic [3:0] wrapOffset;
	logic [3:0] correctedNibble;

	// LS259 style addressable latch
	always_ff @(posedge CLK) begin
		if (reset) begin
			systemLatch <= '0;
		end else if (procEn && latch.strobe) begin
			systemLatch[latch.addr] <= latch.data;
		end
	end

	// Screen size code in latch bits 5:4
	always_comb begin
		case (systemLatch[5:4])
			2'b00: wrapOffset = 4'd8;
			2'b01: wrapOffset = 4'd12;
			2'b10: wrapOffset = 4'd6;
			default: wrapOffset = 4'd11;
		endcase
	end

	// CRTC ran past the top of RAM, fold back into the screen area
	// The 4-bit sum wraps naturally
	always_comb begin
		if (frameStoreAddr[12]) begin
			correctedNibble = frameStoreAddr[11:8] + wrapOffset;
		end else begin
			correctedNibble = frameStoreAddr[11:8];
		end
	end

	// Teletext reads a linear 1K block at 7C00
	assign videoAddr = txtMode ? {5'b11111, frameStoreAddr[9:0]}
		: {correctedNibble, frameStoreAddr[7:0], rowAddress[2:0]};

endmodule

// File: hw/sheilaDecoder.sv
`timescale 1ns/1ps

`include "bbc_macros.svh"

module sheilaDecoder (
	input  bbcPkg::cpuBusT   cpuBus,
	output bbcPkg::ioDeviceE ioDevice,
	output logic             slowAccess
);

	import bbcPkg::*;

	logic inSheila;

	assign inSheila = (cpuBus.addr[15:8] == `SHEILA_PAGE);

	always_comb begin
		ioDevice = ioNone;
		if (inSheila) begin
			casez (cpuBus.addr[7:0])
				8'b0000_0???: ioDevice = ioCrtc;
				8'b0000_1???: ioDevice = ioAcia;
				// Video ULA and ROM select are write only
				8'b0010_????: begin
					if (!cpuBus.rnw) begin
						ioDevice = ioVidProc;
					end
				end
				8'b0011_????: begin
					if (!cpuBus.rnw) begin
						ioDevice = ioRomSel;
					end
				end
				8'b010?_????: ioDevice = ioSysVia;
				8'b011?_????: ioDevice = ioUsrVia;
				8'b100?_????: ioDevice = ioFdc;
				8'b101?_????: ioDevice = ioAdlc;
				8'b110?_????: ioDevice = ioAdc;
				8'b111?_????: ioDevice = ioTube;
				default: ioDevice = ioNone;
			endcase
		end
	end

	// 1 MHz peripherals, the processor must wait for ioEn
	assign slowAccess = ioDevice inside {ioCrtc, ioAcia, ioSysVia, ioUsrVia, ioAdc};

endmodule

// File: hw/timingGen.sv
`timescale 1ns/1ps

`include "bbc_macros.svh"

module timingGen (
	input  logic CLK,
	input  logic reset,
	output logic ramEn,
	output logic procEn,
	output logic ioEn
);

	logic [`IO_DIVIDE_BITS-1:0] phase;

	// Free running phase counter, wraps after 7
	always_ff @(posedge CLK) begin
		if (reset) begin
			phase <= '0;
		end else begin
			phase <= phase + 1'b1;
		end
	end

	// RAM runs at half rate, odd phases only
	assign ramEn = phase[0];

	// Processor at quarter rate, lands on phases 3 and 7
	// These double as the video slots
	assign procEn = &phase[1:0];

	// Slow I/O cycle once per full turn
	assign ioEn = &phase;

endmodule

// File: include/bbc_macros.svh
`ifndef BBC_MACROS_SVH
`define BBC_MACROS_SVH

// Main RAM depth in bytes, shared by processor and video
`define RAM_WORDS 32768

// Depth of the OS ROM and of each sideways bank
`define ROM_WORDS 16384

// Paged ROM banks in the 8000 to BFFF window
`define SIDEWAYS_BANKS 4

// High address byte of the memory mapped I/O page
`define SHEILA_PAGE 8'hFE

// Width of the phase counter
// 8 phases give the 4/2/1 enable ratio
`define IO_DIVIDE_BITS 3

`endif

// File: sim/bbcMemoryCoreTb.sv
`timescale 1ns/1ps

`include "bbc_macros.svh"

module bbcMemoryCoreTb;

	import bbcPkg::*;

	localparam int RandomOps = 200;
	localparam int NumOps = `RAM_WORDS + 8 * RandomOps;
	localparam int RomLoadCycles = 5 * `ROM_WORDS;
	localparam int TimeoutCycles = NumOps * 8 + RomLoadCycles + 1000;

	logic CLK;
	logic reset;
	cpuBusT cpuBus;
	romLoadT romLoad;
	latchWriteT latch;
	logic [13:0] frameStoreAddr;
	logic [4:0] rowAddress;
	logic txtMode;
	logic [7:0] readData;
	logic [7:0] videoData;
	ioDeviceE ioDevice;
	logic cpuEn;
	logic [7:0] systemLatch;

	// Reference memory model
	logic [7:0] modelRam [`RAM_WORDS];
	bit ramKnown [`RAM_WORDS];
	logic [7:0] modelOs [`ROM_WORDS];
	logic [7:0] modelBank [`SIDEWAYS_BANKS][`ROM_WORDS];
	logic [1:0] modelRomSel;
	logic [7:0] modelLatch;
	logic [2:0] modelPhase;
	int wrapOffsets [4] = '{8, 12, 6, 11};
	int seed = 19581;
	int errorCount;
	int checkCount;
	int cycleCount;
	int lastPulse;
	logic [2:0] lastPhase;
	bit videoPending;
	logic [7:0] videoExpect;

	bbcMemoryCore DUT (.*);

	initial begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;
	end

	function automatic logic [31:0] nextRandom();
		return $random(seed);
	endfunction

	function automatic logic [7:0] ramPattern(logic [14:0] addr);
		return addr[7:0] ^ addr[14:7];
	endfunction

	function automatic logic [7:0] romPattern(int sel, logic [13:0] addr);
		logic [31:0] mix;
		mix = {18'd0, addr} * 32'd7 + sel * 32'd61;
		return mix[7:0] ^ {2'b00, addr[13:8]};
	endfunction

	function automatic ioDeviceE expectDevice(cpuBusT bus);
		logic [7:0] low;
		low = bus.addr[7:0];
		if (bus.addr[15:8] != `SHEILA_PAGE) return ioNone;
		if (low < 8'h08) return ioCrtc;
		if (low < 8'h10) return ioAcia;
		if (low < 8'h20) return ioNone;
		if (low < 8'h30) return bus.rnw ? ioNone : ioVidProc;
		if (low < 8'h40) return bus.rnw ? ioNone : ioRomSel;
		if (low < 8'h60) return ioSysVia;
		if (low < 8'h80) return ioUsrVia;
		if (low < 8'hA0) return ioFdc;
		if (low < 8'hC0) return ioAdlc;
		if (low < 8'hE0) return ioAdc;
		return ioTube;
	endfunction

	function automatic logic [7:0] expectRead(logic [15:0] addr);
		if (addr[15:8] == `SHEILA_PAGE) return 8'hFF;
		if (!addr[15]) return modelRam[addr[14:0]];
		if (addr[14]) return modelOs[addr[13:0]];
		return modelBank[modelRomSel][addr[13:0]];
	endfunction

	function automatic logic [14:0] expectVideoAddr(logic [13:0] fsa, logic [4:0] row,
		logic txt, logic [7:0] lat);
		int sum;
		if (txt) return {5'b11111, fsa[9:0]};
		sum = int'(fsa[11:8]) + (fsa[12] ? wrapOffsets[lat[5:4]] : 0);
		sum = sum % 16;
		return {sum[3:0], fsa[7:0], row[2:0]};
	endfunction

	task automatic compareValue(string name, logic [31:0] got, logic [31:0] expected);
		checkCount++;
		assert (got === expected) else begin
			errorCount++;
			$display("FAILED %0t %s: got %0h expected %0h", $time, name, got, expected);
		end
	endtask

	// Returns just after the rising edge that ends the current bus cycle
	task automatic waitPulse();
		@(negedge CLK);
		while (!cpuEn) begin
			@(negedge CLK);
		end
		@(posedge CLK);
	endtask

	task automatic issue(logic [15:0] busAddr, logic [7:0] busData, logic busRnw);
		waitPulse();
		cpuBus <= {busAddr, busData, busRnw};
	endtask

	task automatic writeLatch(logic [2:0] bitAddr, logic value);
		waitPulse();
		latch <= {1'b1, bitAddr, value};
		waitPulse();
		latch <= '0;
	endtask

	task automatic loadRom(logic osRom, logic [1:0] bank);
		logic [7:0] value;
		for (int i = 0; i < `ROM_WORDS; i++) begin
			value = romPattern(osRom ? 4 : int'(bank), i[13:0]);
			@(posedge CLK);
			romLoad <= {1'b1, osRom, bank, i[13:0], value};
			if (osRom) begin
				modelOs[i] = value;
			end else begin
				modelBank[bank][i] = value;
			end
		end
		@(posedge CLK);
		romLoad <= '0;
	endtask

	always @(posedge CLK) begin
		if (reset) begin
			modelPhase <= 3'd0;
		end else begin
			modelPhase <= modelPhase + 3'd1;
		end
	end

	// Compare process, samples mid cycle
	always @(negedge CLK) begin
		ioDeviceE dev;
		logic [14:0] vAddr;
		int expGap;
		if (reset) begin
			modelLatch = '0;
			modelRomSel = '0;
		end else begin
			cycleCount++;
			dev = expectDevice(cpuBus);
			vAddr = expectVideoAddr(frameStoreAddr, rowAddress, txtMode, modelLatch);
			compareValue("videoAddr", 32'(DUT.videoAddr), 32'(vAddr));
			compareValue("systemLatch", 32'(systemLatch), 32'(modelLatch));
			if (videoPending) begin
				compareValue("videoData", 32'(videoData), 32'(videoExpect));
			end
			videoPending = 1'b0;
			if (cpuEn) begin
				compareValue("ioDevice", 32'(ioDevice), 32'(dev));
				if (cpuBus.rnw) begin
					compareValue("readData", 32'(readData), 32'(expectRead(cpuBus.addr)));
				end
				// Slow devices wait for the next phase 7
				expGap = (dev inside {ioCrtc, ioAcia, ioSysVia, ioUsrVia, ioAdc}
					&& lastPhase == 3'd7) ? 8 : 4;
				if (lastPulse > 0) begin
					compareValue("cpuEn interval", cycleCount - lastPulse, expGap);
				end
				lastPulse = cycleCount;
				lastPhase = modelPhase;
				if (!cpuBus.rnw && !cpuBus.addr[15]) begin
					modelRam[cpuBus.addr[14:0]] = cpuBus.wData;
					ramKnown[cpuBus.addr[14:0]] = 1'b1;
				end
				if (dev == ioRomSel) begin
					modelRomSel = cpuBus.wData[1:0];
				end
			end
			// Video slot and latch write share the procEn phases
			if (modelPhase[1:0] == 2'b11) begin
				if (latch.strobe) begin
					modelLatch[latch.addr] = latch.data;
				end
				if (ramKnown[vAddr]) begin
					videoPending = 1'b1;
					videoExpect = modelRam[vAddr];
				end
			end
		end
	end

	initial begin
		logic [31:0] r;
		logic [15:0] a;
		reset = 1'b1;
		cpuBus = {16'hFE10, 8'h00, 1'b1};
		romLoad = '0;
		latch = '0;
		frameStoreAddr = '0;
		rowAddress = '0;
		txtMode = 1'b0;
		repeat (2) @(posedge CLK);
		reset <= 1'b0;

		loadRom(1'b1, 2'd0);
		for (int b = 0; b < `SIDEWAYS_BANKS; b++) begin
			loadRom(1'b0, b[1:0]);
		end
		for (int i = 0; i < `RAM_WORDS; i++) begin
			issue({1'b0, i[14:0]}, ramPattern(i[14:0]), 1'b0);
		end

		// RAM read back, then ROM writes that must be ignored
		repeat (RandomOps) begin
			r = nextRandom();
			issue({1'b0, r[14:0]}, r[22:15], 1'b0);
			issue({1'b0, r[14:0]}, 8'h00, 1'b1);
		end
		repeat (RandomOps) begin
			r = nextRandom();
			a = {1'b1, r[14:0]};
			if (a[15:9] == 7'h7F) begin
				a[9] = 1'b0;
			end
			issue(a, r[23:16], 1'b0);
			issue(a, 8'h00, 1'b1);
		end

		for (int b = 0; b < `SIDEWAYS_BANKS; b++) begin
			r = nextRandom();
			issue({12'hFE3, r[3:0]}, {r[9:4], b[1:0]}, 1'b0);
			repeat (RandomOps / 8) begin
				r = nextRandom();
				issue({2'b10, r[13:0]}, 8'h00, 1'b1);
			end
		end
		repeat (RandomOps / 2) begin
			r = nextRandom();
			a = {2'b11, r[13:0]};
			if (a[15:8] == `SHEILA_PAGE) begin
				a[9] = 1'b0;
			end
			issue(a, 8'h00, 1'b1);
		end

		// Random SHEILA traffic, slow and fast
		repeat (RandomOps) begin
			r = nextRandom();
			issue({`SHEILA_PAGE, r[7:0]}, r[15:8], r[16]);
		end
		issue(16'hFE10, 8'h00, 1'b1);

		repeat (8) begin
			r = nextRandom();
			writeLatch(r[2:0], r[3]);
		end
		for (int code = 0; code < 4; code++) begin
			writeLatch(3'd4, code[0]);
			writeLatch(3'd5, code[1]);
			repeat (RandomOps / 4) begin
				r = nextRandom();
				@(posedge CLK);
				frameStoreAddr <= r[13:0];
				rowAddress <= r[18:14];
				txtMode <= r[19];
			end
		end

		issue(16'hFE10, 8'h00, 1'b1);
		issue(16'hFE10, 8'h00, 1'b1);
		@(negedge CLK);
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	initial begin
		int limitCount;
		limitCount = 0;
		while (limitCount < TimeoutCycles) begin
			@(posedge CLK);
			limitCount++;
		end
		$display("Timeout: stimulus still running after %0d cycles", TimeoutCycles);
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

// File: sim/bbcMemoryCore_assertions.sv
`timescale 1ns/1ps

`include "bbc_macros.svh"

module bbcMemoryCoreAssertions (
	input logic             CLK,
	input logic             reset,
	input logic             procEn,
	input logic             cpuEn,
	input bbcPkg::cpuBusT   cpuBus,
	input bbcPkg::ioDeviceE ioDevice,
	input logic             txtMode,
	input logic [14:0]      videoAddr
);

	import bbcPkg::*;

	// ioEn phases are a subset of the procEn phases
	cpuEnInProcPhase: assert property (@(posedge CLK) disable iff (reset) cpuEn |-> procEn)
		else $error("cpuEn high outside a procEn phase");

	deviceOnlyInSheila: assert property (@(posedge CLK) disable iff (reset)
		(cpuBus.addr[15:8] != `SHEILA_PAGE) |-> (ioDevice == ioNone))
		else $error("I/O device selected outside the SHEILA page");

	// Teletext block sits at the top of RAM
	textModeTopBlock: assert property (@(posedge CLK) disable iff (reset)
		txtMode |-> (&videoAddr[14:10]))
		else $error("text mode video address outside the 7C00 block");

endmodule

bind bbcMemoryCore bbcMemoryCoreAssertions protocolChecks (
	.CLK       (CLK),
	.reset     (reset),
	.procEn    (procEn),
	.cpuEn     (cpuEn),
	.cpuBus    (cpuBus),
	.ioDevice  (ioDevice),
	.txtMode   (txtMode),
	.videoAddr (videoAddr)
);
